/* Makefile */
TOP  = decode_frontend_tb
LIST = decode_frontend.f

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module decode_frontend -f $(LIST)

sim:
	verilator --binary --timing --top-module $(TOP) -f $(LIST) --Mdir obj_dir -o sim_tb
	./obj_dir/sim_tb | tee sim.log
	grep -qx "test passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* decode_frontend.f */
src/frontend_pkg.sv
src/fetch_unit.sv
src/reg_field_decoder.sv
src/imm_generator.sv
src/ctl_word_builder.sv
src/decode_frontend.sv
tb/decode_frontend_tb.sv

/* src/ctl_word_builder.sv */
`default_nettype none

module ctl_word_builder import frontend_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        flush,

    input  logic        in_valid,
    output logic        in_ready,
    input  reg_fields_t fields,
    input  imm_t        imm,
    input  rv32i_word   pc,

    output logic        dispatch_valid,
    input  logic        dispatch_ready,
    output ctl_word_t   dispatch_word
);

    ctl_word_t word_next;
    logic      load;

    always_comb begin
        word_next.fields = fields;
        word_next.imm    = imm;
        word_next.pc     = pc;
    end

    // The register can take a new word if it is empty or drains this cycle.
    assign in_ready = !dispatch_valid || dispatch_ready;
    assign load     = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            dispatch_valid <= 1'b0;
        end else if (flush) begin
            dispatch_valid <= 1'b0;
        end else if (in_ready) begin
            dispatch_valid <= in_valid;
        end
    end

    // Payload only moves on a load, so a stalled word stays stable.
    always_ff @(posedge clk) begin
        if (load) begin
            dispatch_word <= word_next;
        end
    end

endmodule : ctl_word_builder

`default_nettype wire

/* src/decode_frontend.sv */
`default_nettype none

module decode_frontend import frontend_pkg::*; #(
    parameter rv32i_word RESET_PC = 32'h0000_0000
) (
    input  logic      clk,
    input  logic      rst,

    output logic      imem_read,
    output rv32i_word imem_addr,
    input  logic      imem_resp,
    input  rv32i_word imem_rdata,

    input  logic      redirect_valid,
    input  rv32i_word redirect_pc,

    output logic      dispatch_valid,
    input  logic      dispatch_ready,
    output ctl_word_t dispatch_word
);

    logic        ir_valid;
    logic        ir_ready;
    rv32i_word   ir_instr;
    rv32i_word   ir_pc;
    reg_fields_t fields;
    imm_t        imm;

    fetch_unit #(
        .RESET_PC(RESET_PC)
    ) fetch_unit_inst (
        .clk(clk),
        .rst(rst),
        .imem_read(imem_read),
        .imem_addr(imem_addr),
        .imem_resp(imem_resp),
        .imem_rdata(imem_rdata),
        .redirect_valid(redirect_valid),
        .redirect_pc(redirect_pc),
        .ir_valid(ir_valid),
        .ir_instr(ir_instr),
        .ir_pc(ir_pc),
        .ir_ready(ir_ready)
    );

    reg_field_decoder reg_field_decoder_inst (
        .instr(ir_instr),
        .fields(fields)
    );

    imm_generator imm_generator_inst (
        .instr(ir_instr),
        .imm(imm)
    );

    ctl_word_builder ctl_word_builder_inst (
        .clk(clk),
        .rst(rst),
        .flush(redirect_valid),
        .in_valid(ir_valid),
        .in_ready(ir_ready),
        .fields(fields),
        .imm(imm),
        .pc(ir_pc),
        .dispatch_valid(dispatch_valid),
        .dispatch_ready(dispatch_ready),
        .dispatch_word(dispatch_word)
    );

endmodule : decode_frontend

`default_nettype wire

/* src/fetch_unit.sv */
`default_nettype none

module fetch_unit import frontend_pkg::*; #(
    parameter rv32i_word RESET_PC = 32'h0000_0000
) (
    input  logic      clk,
    input  logic      rst,

    output logic      imem_read,
    output rv32i_word imem_addr,
    input  logic      imem_resp,
    input  rv32i_word imem_rdata,

    input  logic      redirect_valid,
    input  rv32i_word redirect_pc,

    output logic      ir_valid,
    output rv32i_word ir_instr,
    output rv32i_word ir_pc,
    input  logic      ir_ready
);

    fetch_state_e state;
    fetch_state_e state_next;
    rv32i_word    pc;
    rv32i_word    pc_next;
    rv32i_word    req_addr;
    logic         drop;
    logic         ir_free;
    logic         resp_live;
    logic         launch;

    // The address is held in its own register so that a redirect can move
    // the pc while the old request is still waiting for its response.
    assign imem_read = (state == F_REQ);
    assign imem_addr = req_addr;

    assign ir_free   = !ir_valid || ir_ready;
    assign resp_live = (state == F_REQ) && imem_resp && !drop && !redirect_valid;

    always_comb begin
        if (redirect_valid) begin
            pc_next = redirect_pc;
        end else if (resp_live) begin
            pc_next = pc + 32'd4;
        end else begin
            pc_next = pc;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            F_IDLE: begin
                state_next = F_REQ;
            end
            F_REQ: begin
                if (imem_resp) begin
                    if (drop) begin
                        state_next = F_IDLE;
                    end else if (redirect_valid) begin
                        state_next = F_REQ;
                    end else begin
                        state_next = F_HOLD;
                    end
                end
            end
            F_HOLD: begin
                if (redirect_valid || ir_free) begin
                    state_next = F_REQ;
                end
            end
            default: begin
                state_next = F_REQ;
            end
        endcase
    end

    // A new read begins whenever F_REQ is entered or re-entered after a response.
    assign launch = (state_next == F_REQ) && !((state == F_REQ) && !imem_resp);

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= F_REQ;
            pc       <= RESET_PC;
            req_addr <= RESET_PC;
            drop     <= 1'b0;
            ir_valid <= 1'b0;
        end else begin
            state <= state_next;
            pc    <= pc_next;
            if (launch) begin
                req_addr <= pc_next;
            end

            // A response that arrives with the redirect completes the read, so
            // only a read still waiting afterwards needs to be marked stale.
            if ((state == F_REQ) && imem_resp) begin
                drop <= 1'b0;
            end else if ((state == F_REQ) && redirect_valid) begin
                drop <= 1'b1;
            end

            if (redirect_valid) begin
                ir_valid <= 1'b0;
            end else if (resp_live) begin
                ir_valid <= 1'b1;
            end else if (ir_ready) begin
                ir_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (resp_live) begin
            ir_instr <= imem_rdata;
            ir_pc    <= req_addr;
        end
    end

endmodule : fetch_unit

`default_nettype wire

/* src/frontend_pkg.sv */
`default_nettype none

package frontend_pkg;

    typedef logic [31:0] rv32i_word;
    typedef logic [4:0]  rv32i_reg;

    // The major opcodes of the RV32I base set sit in bits 6:0 of the instruction.
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011,
        op_csr   = 7'b1110011
    } rv32i_opcode;

    // The operation class lets dispatch pick a reservation station.
    typedef enum logic [2:0] {
        OPC_ALU,
        OPC_BRANCH,
        OPC_JUMP,
        OPC_LOAD,
        OPC_STORE,
        OPC_UPPER,
        OPC_SYSTEM,
        OPC_ILLEGAL
    } op_class_e;

    // Register-side decode of one instruction.
    typedef struct packed {
        op_class_e op_class;
        rv32i_reg  src1_reg;
        rv32i_reg  src2_reg;
        logic      src1_used;
        logic      src2_used;
        rv32i_reg  rd;
        logic      rd_write;
        logic [2:0] funct3;
        logic      funct7_bit;
    } reg_fields_t;

    // Sign-extended immediate and whether the operation consumes it.
    typedef struct packed {
        rv32i_word imm;
        logic      imm_used;
    } imm_t;

    // Payload handed to dispatch.
    typedef struct packed {
        reg_fields_t fields;
        imm_t        imm;
        rv32i_word   pc;
    } ctl_word_t;

    // Fetch sequencer states.
    // F_REQ has a read outstanding on the memory port; F_HOLD waits for room in the IR.
    // F_IDLE is the single cycle after a squashed response has been consumed.
    typedef enum logic [1:0] {
        F_IDLE,
        F_REQ,
        F_HOLD
    } fetch_state_e;

endpackage : frontend_pkg

`default_nettype wire

/* src/imm_generator.sv */
`default_nettype none

module imm_generator import frontend_pkg::*; (
    input  rv32i_word instr,
    output imm_t      imm
);

    rv32i_opcode opcode;
    rv32i_word   i_imm;
    rv32i_word   s_imm;
    rv32i_word   b_imm;
    rv32i_word   u_imm;
    rv32i_word   j_imm;

    assign opcode = rv32i_opcode'(instr[6:0]);

    // Bit 31 is the sign bit in every format.
    assign i_imm = {{21{instr[31]}}, instr[30:20]};
    assign s_imm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
    assign b_imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign u_imm = {instr[31:12], 12'h000};
    assign j_imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        imm.imm      = '0;
        imm.imm_used = 1'b1;
        case (opcode)
            op_lui, op_auipc: begin
                imm.imm = u_imm;
            end
            op_jal: begin
                imm.imm = j_imm;
            end
            op_br: begin
                imm.imm = b_imm;
            end
            op_store: begin
                imm.imm = s_imm;
            end
            op_jalr, op_load, op_imm, op_csr: begin
                imm.imm = i_imm;
            end
            default: begin
                // Register-register and unknown opcodes carry no immediate.
                imm.imm_used = 1'b0;
            end
        endcase
    end

endmodule : imm_generator

`default_nettype wire

/* src/reg_field_decoder.sv */
`default_nettype none

module reg_field_decoder import frontend_pkg::*; (
    input  rv32i_word   instr,
    output reg_fields_t fields
);

    rv32i_opcode opcode;
    logic        writes_rd;

    assign opcode = rv32i_opcode'(instr[6:0]);

    always_comb begin
        fields.src1_reg   = instr[19:15];
        fields.src2_reg   = instr[24:20];
        fields.rd         = instr[11:7];
        fields.funct3     = instr[14:12];
        fields.funct7_bit = instr[30];

        fields.op_class  = OPC_ILLEGAL;
        fields.src1_used = 1'b0;
        fields.src2_used = 1'b0;
        writes_rd        = 1'b1;

        case (opcode)
            op_lui, op_auipc: begin
                fields.op_class = OPC_UPPER;
            end
            op_jal: begin
                fields.op_class = OPC_JUMP;
            end
            op_jalr: begin
                fields.op_class  = OPC_JUMP;
                fields.src1_used = 1'b1;
            end
            op_br: begin
                fields.op_class  = OPC_BRANCH;
                fields.src1_used = 1'b1;
                fields.src2_used = 1'b1;
                writes_rd        = 1'b0;
            end
            op_load: begin
                fields.op_class  = OPC_LOAD;
                fields.src1_used = 1'b1;
            end
            op_store: begin
                fields.op_class  = OPC_STORE;
                fields.src1_used = 1'b1;
                fields.src2_used = 1'b1;
                writes_rd        = 1'b0;
            end
            op_imm: begin
                fields.op_class  = OPC_ALU;
                fields.src1_used = 1'b1;
            end
            op_reg: begin
                fields.op_class  = OPC_ALU;
                fields.src1_used = 1'b1;
                fields.src2_used = 1'b1;
            end
            op_csr: begin
                fields.op_class  = OPC_SYSTEM;
                fields.src1_used = 1'b1;
            end
            default: begin
                writes_rd = 1'b0;
            end
        endcase

        // Register 0 is hardwired, so a write to it is never scheduled.
        fields.rd_write = writes_rd && (instr[11:7] != 5'd0);
    end

endmodule : reg_field_decoder

`default_nettype wire

/* tb/decode_frontend_tb.sv */
`default_nettype none

module decode_frontend_tb import frontend_pkg::*; ();

    localparam int        NUM_TESTS    = 12;
    localparam int        RESET_CYCLES = 16;
    localparam int        CYCLE_LIMIT  = NUM_TESTS * 12 + RESET_CYCLES;
    localparam int        CW           = $bits(ctl_word_t);
    localparam rv32i_word START_PC     = 32'h0000_1000;

    logic      clk = 1'b0;
    logic      rst;
    logic      imem_read;
    rv32i_word imem_addr;
    logic      imem_resp;
    rv32i_word imem_rdata;
    logic      redirect_valid;
    rv32i_word redirect_pc;
    logic      dispatch_valid;
    logic      dispatch_ready;
    ctl_word_t dispatch_word;

    // The program table holds one row per instruction in dispatch order.
    string     test_name   [NUM_TESTS];
    rv32i_word test_instr  [NUM_TESTS];
    rv32i_word test_pc     [NUM_TESTS];
    ctl_word_t test_exp    [NUM_TESTS];
    logic      test_redir  [NUM_TESTS];
    rv32i_word test_target [NUM_TESTS];
    int        num_entries;
    rv32i_word table_pc;

    logic [31:0] rng_state;
    int          cycle_count = 0;
    logic        mem_busy;
    int          mem_wait;
    rv32i_word   mem_addr;

    decode_frontend #(
        .RESET_PC(START_PC)
    ) decode_frontend_inst (
        .clk(clk),
        .rst(rst),
        .imem_read(imem_read),
        .imem_addr(imem_addr),
        .imem_resp(imem_resp),
        .imem_rdata(imem_rdata),
        .redirect_valid(redirect_valid),
        .redirect_pc(redirect_pc),
        .dispatch_valid(dispatch_valid),
        .dispatch_ready(dispatch_ready),
        .dispatch_word(dispatch_word)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles before the whole table was dispatched",
                     cycle_count);
            $display("test failed");
            $fatal(1, "simulation ran past its cycle limit");
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int random_below(input int bound);
        rng_state = xorshift32(rng_state);
        return int'(rng_state % 32'(bound));
    endfunction

    // Addresses outside the table return a pattern built from the address.
    function automatic rv32i_word fetch_word(input rv32i_word addr);
        rv32i_word word;
        word = addr ^ 32'h5a5a_a5a5;
        for (int i = 0; i < NUM_TESTS; i++) begin
            if (test_pc[i] == addr) begin
                word = test_instr[i];
            end
        end
        return word;
    endfunction

    task automatic check_value(input string name, input logic [CW-1:0] expected,
                               input logic [CW-1:0] actual);
        if (actual !== expected) begin
            $display("error %s expected %0h actual %0h", name, expected, actual);
            $display("test failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic add_entry(input string name, input rv32i_word instr,
                             input reg_fields_t fields, input imm_t imm,
                             input logic redir, input rv32i_word target);
        test_name[num_entries]   = name;
        test_instr[num_entries]  = instr;
        test_pc[num_entries]     = table_pc;
        test_exp[num_entries]    = {fields, imm, table_pc};
        test_redir[num_entries]  = redir;
        test_target[num_entries] = target;
        table_pc    = redir ? target : table_pc + 32'd4;
        num_entries = num_entries + 1;
    endtask

    // Each row lists the class, rs1, rs2, rs1 used, rs2 used, rd, rd write, funct3 and bit 30.
    task automatic build_table();
        add_entry("lui_pos", 32'h1234_52b7,
            reg_fields_t'{OPC_UPPER, 5'd8, 5'd3, 1'b0, 1'b0, 5'd5, 1'b1, 3'd5, 1'b0},
            imm_t'{32'h1234_5000, 1'b1}, 1'b0, 32'h0);
        add_entry("auipc_neg", 32'h8000_0097,
            reg_fields_t'{OPC_UPPER, 5'd0, 5'd0, 1'b0, 1'b0, 5'd1, 1'b1, 3'd0, 1'b0},
            imm_t'{32'h8000_0000, 1'b1}, 1'b0, 32'h0);
        add_entry("addi_neg", 32'hfff1_0193,
            reg_fields_t'{OPC_ALU, 5'd2, 5'd31, 1'b1, 1'b0, 5'd3, 1'b1, 3'd0, 1'b1},
            imm_t'{32'hffff_ffff, 1'b1}, 1'b0, 32'h0);
        add_entry("add_reg", 32'h0020_8233,
            reg_fields_t'{OPC_ALU, 5'd1, 5'd2, 1'b1, 1'b1, 5'd4, 1'b1, 3'd0, 1'b0},
            imm_t'{32'h0000_0000, 1'b0}, 1'b0, 32'h0);
        add_entry("lw_pos", 32'h0081_2303,
            reg_fields_t'{OPC_LOAD, 5'd2, 5'd8, 1'b1, 1'b0, 5'd6, 1'b1, 3'd2, 1'b0},
            imm_t'{32'h0000_0008, 1'b1}, 1'b1, 32'h0000_2000);
        add_entry("sw_neg", 32'hfe71_2e23,
            reg_fields_t'{OPC_STORE, 5'd2, 5'd7, 1'b1, 1'b1, 5'd28, 1'b0, 3'd2, 1'b1},
            imm_t'{32'hffff_fffc, 1'b1}, 1'b0, 32'h0);
        add_entry("beq_neg", 32'hfe20_8ce3,
            reg_fields_t'{OPC_BRANCH, 5'd1, 5'd2, 1'b1, 1'b1, 5'd25, 1'b0, 3'd0, 1'b1},
            imm_t'{32'hffff_fff8, 1'b1}, 1'b0, 32'h0);
        // The redirect after the jump lands on its own target.
        add_entry("jal_pos", 32'h0010_00ef,
            reg_fields_t'{OPC_JUMP, 5'd0, 5'd1, 1'b0, 1'b0, 5'd1, 1'b1, 3'd0, 1'b0},
            imm_t'{32'h0000_0800, 1'b1}, 1'b1, 32'h0000_2808);
        add_entry("jalr_rd0", 32'h0000_8067,
            reg_fields_t'{OPC_JUMP, 5'd1, 5'd0, 1'b1, 1'b0, 5'd0, 1'b0, 3'd0, 1'b0},
            imm_t'{32'h0000_0000, 1'b1}, 1'b0, 32'h0);
        add_entry("illegal", 32'h00a5_8a7f,
            reg_fields_t'{OPC_ILLEGAL, 5'd11, 5'd10, 1'b0, 1'b0, 5'd20, 1'b0, 3'd0, 1'b0},
            imm_t'{32'h0000_0000, 1'b0}, 1'b0, 32'h0);
        add_entry("csr_sys", 32'h3054_9473,
            reg_fields_t'{OPC_SYSTEM, 5'd9, 5'd5, 1'b1, 1'b0, 5'd8, 1'b1, 3'd1, 1'b0},
            imm_t'{32'h0000_0305, 1'b1}, 1'b0, 32'h0);
        add_entry("jal_neg", 32'hffdf_f16f,
            reg_fields_t'{OPC_JUMP, 5'd31, 5'd29, 1'b0, 1'b0, 5'd2, 1'b1, 3'd7, 1'b1},
            imm_t'{32'hffff_fffc, 1'b1}, 1'b0, 32'h0);
    endtask

    // The memory model serves one read at a time and answers after 1 to 4 cycles.
    task automatic memory_step();
        imem_resp <= 1'b0;
        if (imem_resp) begin
            mem_busy = 1'b0;
        end else if (mem_busy) begin
            if (mem_wait == 0) begin
                imem_resp  <= 1'b1;
                imem_rdata <= fetch_word(mem_addr);
            end else begin
                mem_wait = mem_wait - 1;
            end
        end else if (imem_read) begin
            mem_busy = 1'b1;
            mem_addr = imem_addr;
            mem_wait = random_below(4);
        end
    endtask

    initial begin
        logic      fire;
        ctl_word_t got;
        int        idx;

        rst            = 1'b1;
        imem_resp      = 1'b0;
        imem_rdata     = '0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        dispatch_ready = 1'b0;
        rng_state      = 32'h0ee2fc0b;
        mem_busy       = 1'b0;
        mem_wait       = 0;
        mem_addr       = '0;
        num_entries    = 0;
        table_pc       = START_PC;
        build_table();

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_value("reset_dispatch_valid", CW'(1'b0), CW'(dispatch_valid));
        check_value("reset_imem_read", CW'(1'b1), CW'(imem_read));
        check_value("reset_imem_addr", CW'(START_PC), CW'(imem_addr));

        idx = 0;
        while (idx < NUM_TESTS) begin
            @(posedge clk);
            fire = dispatch_valid && dispatch_ready;
            got  = dispatch_word;
            memory_step();
            redirect_valid <= 1'b0;
            dispatch_ready <= (random_below(3) != 0);
            if (fire) begin
                check_value(test_name[idx], test_exp[idx], got);
                // Ready stays low in the redirect cycle so no flushed word can transfer.
                if (test_redir[idx]) begin
                    redirect_valid <= 1'b1;
                    redirect_pc    <= test_target[idx];
                    dispatch_ready <= 1'b0;
                end
                idx = idx + 1;
            end
        end

        $display("test passed");
        $finish;
    end

endmodule : decode_frontend_tb

`default_nettype wire
